// ==== tb/lsu_trace.txt ====
# op size(0 byte 1 half 2 word) unsigned addr wdata exp_sel exp_rdata
# hex for addr, wdata, sel and rdata; rdata is checked on loads only
st 2 0 00000010 12345678 f 00000000
ld 2 0 00000010 00000000 f 12345678
st 0 0 00000020 000000a1 1 00000000
st 0 0 00000021 555555b2 2 00000000
st 0 0 00000022 000000c3 4 00000000
st 0 0 00000023 ffffffd4 8 00000000
ld 2 0 00000020 00000000 f d4c3b2a1
st 1 0 00000030 00008001 3 00000000
st 1 0 00000032 12347ffe c 00000000
ld 2 0 00000030 00000000 f 7ffe8001
ld 1 0 00000030 00000000 3 ffff8001
ld 1 1 00000030 00000000 3 00008001
ld 1 0 00000032 00000000 c 00007ffe
ld 1 1 00000032 00000000 c 00007ffe
st 1 0 00000042 0000c234 c 00000000
ld 1 0 00000042 00000000 c ffffc234
ld 1 1 00000042 00000000 c 0000c234
ld 2 0 00000040 00000000 f c2340000
ld 0 0 00000020 00000000 1 ffffffa1
ld 0 1 00000020 00000000 1 000000a1
ld 0 0 00000021 00000000 2 ffffffb2
ld 0 1 00000022 00000000 4 000000c3
ld 0 0 00000023 00000000 8 ffffffd4
ld 0 1 00000023 00000000 8 000000d4
ld 0 0 00000011 00000000 2 00000056
st 2 0 000003fc a5a5a5a5 f 00000000
ld 2 0 000003fc 00000000 f a5a5a5a5
ld 1 1 000003fe 00000000 c 0000a5a5

// ==== sim.f ====
+incdir+verilog
verilog/lsu_pkg.sv
verilog/store_align.sv
verilog/load_align.sv
verilog/wb_mem_master.sv
verilog/lsu_top.sv
tb/tb_clock.sv
tb/wb_ram_model.sv
tb/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_lsu -Mdir "$build_dir" -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_lsu" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$log_file"; then
    exit 1
fi
exit 0

// ==== tb/tb_lsu.sv ====
`timescale 1ns/1ps

module tb_lsu;

localparam int    ram_depth      = 256;
localparam int    rand_seed      = 82;
localparam int    timeout_factor = 10;
localparam int    reset_margin   = 8;
localparam int    drive_delay    = 1;
localparam string trace_path     = "tb/lsu_trace.txt";

logic           clk;
logic           reset;
logic           cmd_valid;
logic           cmd_we;
lsu_pkg::size_t cmd_size;
logic           cmd_unsigned;
lsu_pkg::addr_t cmd_addr;
lsu_pkg::word_t cmd_wdata;
logic           busy;
logic           done;
lsu_pkg::word_t rdata;
logic           wb_cyc;
logic           wb_stb;
logic           wb_we;
lsu_pkg::addr_t wb_adr;
lsu_pkg::sel_t  wb_sel;
lsu_pkg::word_t wb_dat_o;
lsu_pkg::word_t wb_dat_i;
logic           wb_ack;

// One entry per trace command
logic           rec_store[$];
lsu_pkg::size_t rec_size[$];
logic           rec_unsigned[$];
lsu_pkg::addr_t rec_addr[$];
lsu_pkg::word_t rec_wdata[$];
lsu_pkg::sel_t  rec_sel[$];
lsu_pkg::word_t rec_rdata[$];
int             trace_len = 0;

tb_clock #(.half_period(2), .reset_cycles(4)) clock_i (.clk(clk), .reset(reset));

lsu_top dut_i (
    .clk          ( clk          ),
    .reset        ( reset        ),
    .cmd_valid    ( cmd_valid    ),
    .cmd_we       ( cmd_we       ),
    .cmd_size     ( cmd_size     ),
    .cmd_unsigned ( cmd_unsigned ),
    .cmd_addr     ( cmd_addr     ),
    .cmd_wdata    ( cmd_wdata    ),
    .busy         ( busy         ),
    .done         ( done         ),
    .rdata        ( rdata        ),
    .wb_cyc       ( wb_cyc       ),
    .wb_stb       ( wb_stb       ),
    .wb_we        ( wb_we        ),
    .wb_adr       ( wb_adr       ),
    .wb_sel       ( wb_sel       ),
    .wb_dat_o     ( wb_dat_o     ),
    .wb_dat_i     ( wb_dat_i     ),
    .wb_ack       ( wb_ack       )
);

wb_ram_model #(.depth(ram_depth), .seed(rand_seed)) ram_i (
    .clk      ( clk      ),
    .reset    ( reset    ),
    .wb_cyc   ( wb_cyc   ),
    .wb_stb   ( wb_stb   ),
    .wb_we    ( wb_we    ),
    .wb_adr   ( wb_adr   ),
    .wb_sel   ( wb_sel   ),
    .wb_wdata ( wb_dat_o ),
    .wb_rdata ( wb_dat_i ),
    .wb_ack   ( wb_ack   )
);

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        $display("tests failed");
        $fatal(1);
    end
endtask

// Store data as it should appear on the four byte lanes
function automatic lsu_pkg::word_t replicated_lanes(input lsu_pkg::size_t size,
                                                    input lsu_pkg::word_t wdata);
    int             lane_bytes;
    lsu_pkg::word_t lanes;
    lane_bytes = (size == 2'd0) ? 1 : (size == 2'd1) ? 2 : 4;
    for (int k = 0; k < 4; k++) begin
        lanes[8*k +: 8] = wdata[8*(k % lane_bytes) +: 8];
    end
    return lanes;
endfunction

task automatic load_trace();
    int          fd;
    int          fields;
    string       line;
    logic [15:0] op_txt;
    logic [31:0] size_v;
    logic [31:0] uns_v;
    logic [31:0] addr_v;
    logic [31:0] wdata_v;
    logic [31:0] sel_v;
    logic [31:0] rdata_v;
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
        $display("could not open the trace file %s", trace_path);
        $display("tests failed");
        $fatal(1);
    end
    while ($fgets(line, fd) != 0) begin
        // Comment and blank lines
        if (line.len() < 2 || line[0] == "#") continue;
        fields = $sscanf(line, "%s %d %d %h %h %h %h", op_txt, size_v, uns_v,
                         addr_v, wdata_v, sel_v, rdata_v);
        if (fields != 7 || (op_txt != "ld" && op_txt != "st")) begin
            $display("trace line could not be read: %s", line);
            $display("tests failed");
            $fatal(1);
        end
        rec_store.push_back(op_txt == "st");
        rec_size.push_back(size_v[1:0]);
        rec_unsigned.push_back(uns_v[0]);
        rec_addr.push_back(addr_v);
        rec_wdata.push_back(wdata_v);
        rec_sel.push_back(sel_v[3:0]);
        rec_rdata.push_back(rdata_v);
    end
    $fclose(fd);
    if (rec_store.size() == 0) begin
        $display("the trace file holds no commands");
        $display("tests failed");
        $fatal(1);
    end
    trace_len = rec_store.size();
endtask

////////////////////////////////////////
// One command through the bus
////////////////////////////////////////

task automatic run_command(input int idx);
    lsu_pkg::addr_t word_adr;
    lsu_pkg::word_t lane_exp;
    int             bus_cycles;
    word_adr     = {rec_addr[idx][31:2], 2'b00};
    lane_exp     = replicated_lanes(rec_size[idx], rec_wdata[idx]);
    bus_cycles   = 0;
    cmd_we       = rec_store[idx];
    cmd_size     = rec_size[idx];
    cmd_unsigned = rec_unsigned[idx];
    cmd_addr     = rec_addr[idx];
    cmd_wdata    = rec_wdata[idx];
    cmd_valid    = 1'b1;
    @(posedge clk);
    #drive_delay;
    cmd_valid = 1'b0;
    // Request must hold through every wait state
    while (done !== 1'b1) begin
        check_value("busy", 32'd1, 32'(busy));
        check_value("wb_cyc", 32'd1, 32'(wb_cyc));
        check_value("wb_stb", 32'd1, 32'(wb_stb));
        check_value("wb_we", 32'(rec_store[idx]), 32'(wb_we));
        check_value("wb_adr", word_adr, wb_adr);
        check_value("wb_sel", 32'(rec_sel[idx]), 32'(wb_sel));
        if (rec_store[idx]) begin
            check_value("wb_dat_o", lane_exp, wb_dat_o);
        end
        bus_cycles++;
        @(posedge clk);
        #drive_delay;
    end
    check_value("bus cycles before done", 32'd1, 32'(bus_cycles != 0));
    check_value("busy", 32'd1, 32'(busy));
    check_value("wb_cyc", 32'd0, 32'(wb_cyc));
    if (!rec_store[idx]) begin
        check_value("rdata", rec_rdata[idx], rdata);
    end
    @(posedge clk);
    #drive_delay;
    // Single cycle done then back to idle
    check_value("done", 32'd0, 32'(done));
    check_value("busy", 32'd0, 32'(busy));
endtask

initial begin
    cmd_valid    = 1'b0;
    cmd_we       = 1'b0;
    cmd_size     = '0;
    cmd_unsigned = 1'b0;
    cmd_addr     = '0;
    cmd_wdata    = '0;
    load_trace();
    @(negedge reset);
    check_value("busy", 32'd0, 32'(busy));
    check_value("done", 32'd0, 32'(done));
    check_value("wb_cyc", 32'd0, 32'(wb_cyc));
    for (int i = 0; i < trace_len; i++) begin
        run_command(i);
    end
    $display("all tests passed");
    $finish;
end

// Watchdog scaled by the number of commands
initial begin
    wait (trace_len != 0);
    repeat (trace_len * timeout_factor + reset_margin) @(posedge clk);
    $display("timeout after %0d commands worth of clock cycles", trace_len);
    $display("tests failed");
    $fatal(1);
end

endmodule

// ==== tb/wb_ram_model.sv ====
`timescale 1ns/1ps

module wb_ram_model #(
    parameter int depth = 256,
    parameter int seed  = 1
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           wb_we,
    input  lsu_pkg::addr_t wb_adr,
    input  lsu_pkg::sel_t  wb_sel,
    input  lsu_pkg::word_t wb_wdata,
    output lsu_pkg::word_t wb_rdata,
    output logic           wb_ack
);

localparam int index_w = $clog2(depth);

lsu_pkg::word_t     mem [depth];
logic               ack_q = 1'b0;
lsu_pkg::word_t     rdata_q = '0;
logic               pending = 1'b0;
logic [1:0]         wait_left = 2'd0;
bit                 seeded;
logic [index_w-1:0] index;

assign index    = wb_adr[index_w+1:2];
assign wb_ack   = ack_q;
assign wb_rdata = rdata_q;

////////////////////////////////////////
// Slave side with 0 to 3 wait states
////////////////////////////////////////

always @(posedge clk) begin
    int unsigned draw;
    draw = 0;
    if (!seeded) begin
        void'($urandom(seed));
        seeded = 1'b1;
    end
    if (reset) begin
        ack_q     <= 1'b0;
        rdata_q   <= '0;
        pending   <= 1'b0;
        wait_left <= 2'd0;
        for (int i = 0; i < depth; i++) begin
            mem[i] <= '0;
        end
    end else begin
        ack_q <= 1'b0;
        // ack from the previous edge ends the request
        if (wb_cyc && wb_stb && !ack_q) begin
            if (!pending) begin
                draw = $urandom % 4;
            end
            if (pending && wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else if (!pending && draw != 0) begin
                pending   <= 1'b1;
                wait_left <= 2'(draw - 1);
            end else begin
                pending <= 1'b0;
                ack_q   <= 1'b1;
                rdata_q <= mem[index];
                if (wb_we) begin
                    for (int k = 0; k < 4; k++) begin
                        if (wb_sel[k]) mem[index][8*k +: 8] <= wb_wdata[8*k +: 8];
                    end
                end
            end
        end
    end
end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period  = 2,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
end

// Released just after an edge, like the rest of the stimulus
initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
end

endmodule

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
    input  logic           clk,
    input  logic           reset,
    // Command side
    input  logic           cmd_valid,
    input  logic           cmd_we,
    input  lsu_pkg::size_t cmd_size,
    input  logic           cmd_unsigned,
    input  lsu_pkg::addr_t cmd_addr,
    input  lsu_pkg::word_t cmd_wdata,
    output logic           busy,
    output logic           done,
    output lsu_pkg::word_t rdata,
    // Wishbone classic master
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output lsu_pkg::addr_t wb_adr,
    output lsu_pkg::sel_t  wb_sel,
    output lsu_pkg::word_t wb_dat_o,
    input  lsu_pkg::word_t wb_dat_i,
    input  logic           wb_ack
);

lsu_pkg::sel_t    lane_sel;
lsu_pkg::word_t   lane_data;
lsu_pkg::word_t   held_word;
lsu_pkg::offset_t held_offset;
lsu_pkg::size_t   held_size;
logic             held_unsigned;

////////////////////////////////////////
// Store side, on the live command
////////////////////////////////////////

store_align store_align_i (
    .size      ( cmd_size       ),
    .offset    ( cmd_addr[1:0]  ),
    .wdata     ( cmd_wdata      ),
    .sel       ( lane_sel       ),
    .lane_data ( lane_data      )
);

wb_mem_master wb_mem_master_i (
    .clk           ( clk           ),
    .reset         ( reset         ),
    .cmd_valid     ( cmd_valid     ),
    .cmd_we        ( cmd_we        ),
    .cmd_addr      ( cmd_addr      ),
    .cmd_size      ( cmd_size      ),
    .cmd_unsigned  ( cmd_unsigned  ),
    .lane_sel      ( lane_sel      ),
    .lane_data     ( lane_data     ),
    .busy          ( busy          ),
    .done          ( done          ),
    .wb_cyc        ( wb_cyc        ),
    .wb_stb        ( wb_stb        ),
    .wb_we         ( wb_we         ),
    .wb_adr        ( wb_adr        ),
    .wb_sel        ( wb_sel        ),
    .wb_dat_o      ( wb_dat_o      ),
    .wb_dat_i      ( wb_dat_i      ),
    .wb_ack        ( wb_ack        ),
    .held_word     ( held_word     ),
    .held_offset   ( held_offset   ),
    .held_size     ( held_size     ),
    .held_unsigned ( held_unsigned )
);

// Load result from the held access
load_align load_align_i (
    .word        ( held_word     ),
    .offset      ( held_offset   ),
    .size        ( held_size     ),
    .is_unsigned ( held_unsigned ),
    .result      ( rdata         )
);

endmodule

// ==== verilog/wb_mem_master.sv ====
`timescale 1ns/1ps

`include "lsu_params.svh"

module wb_mem_master (
    input  logic             clk,
    input  logic             reset,
    // Command side
    input  logic             cmd_valid,
    input  logic             cmd_we,
    input  lsu_pkg::addr_t   cmd_addr,
    input  lsu_pkg::size_t   cmd_size,
    input  logic             cmd_unsigned,
    input  lsu_pkg::sel_t    lane_sel,
    input  lsu_pkg::word_t   lane_data,
    output logic             busy,
    output logic             done,
    // Wishbone classic master
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output lsu_pkg::addr_t   wb_adr,
    output lsu_pkg::sel_t    wb_sel,
    output lsu_pkg::word_t   wb_dat_o,
    input  lsu_pkg::word_t   wb_dat_i,
    input  logic             wb_ack,
    // Access held for the load aligner
    output lsu_pkg::word_t   held_word,
    output lsu_pkg::offset_t held_offset,
    output lsu_pkg::size_t   held_size,
    output logic             held_unsigned
);

typedef enum logic [1:0] {IDLE, BUS, DONE} wb_state_t;

wb_state_t      state;
logic           accept;
logic           we_q;
lsu_pkg::addr_t adr_q;
lsu_pkg::sel_t  sel_q;
lsu_pkg::word_t dat_q;

assign accept = (state == IDLE) && cmd_valid;

////////////////////////////////////////
// Access FSM
////////////////////////////////////////

always_ff @(posedge clk) begin
    if (reset) begin
        state <= IDLE;
    end else begin
        case (state)
        IDLE: begin
            if (cmd_valid) state <= BUS;
        end
        // Wait states from the slave stretch this state
        BUS: begin
            if (wb_ack) state <= DONE;
        end
        default: state <= IDLE;
        endcase
    end
end

// Command capture and read data on ack
always_ff @(posedge clk) begin
    if (accept) begin
        we_q          <= cmd_we;
        adr_q         <= cmd_addr;
        sel_q         <= lane_sel;
        dat_q         <= lane_data;
        held_size     <= cmd_size;
        held_unsigned <= cmd_unsigned;
    end
    if (state == BUS && wb_ack && !we_q) begin
        held_word <= wb_dat_i;
    end
end

assign busy = (state != IDLE);
assign done = (state == DONE);

assign wb_cyc   = (state == BUS);
assign wb_stb   = (state == BUS);
assign wb_we    = (state == BUS) && we_q;
assign wb_adr   = {adr_q[`LSU_ADDR_W-1:2], 2'b00};
assign wb_sel   = sel_q;
assign wb_dat_o = dat_q;

assign held_offset = adr_q[1:0];

////////////////////////////////////////
// Checks
////////////////////////////////////////

// Driver must wait for done before the next command
a_no_cmd_while_busy: assert property (@(posedge clk) disable iff (reset)
    busy |-> !cmd_valid);

a_half_aligned: assert property (@(posedge clk) disable iff (reset)
    accept && cmd_size == `LSU_SIZE_HALF |-> !cmd_addr[0]);

a_word_aligned: assert property (@(posedge clk) disable iff (reset)
    accept && cmd_size == `LSU_SIZE_WORD |-> cmd_addr[1:0] == 2'b00);

// Master holds the request through wait states
a_bus_stable: assert property (@(posedge clk) disable iff (reset)
    wb_stb && !wb_ack |=> $stable({wb_cyc, wb_stb, wb_we, wb_adr, wb_sel, wb_dat_o}));

endmodule

// ==== verilog/load_align.sv ====
`timescale 1ns/1ps

`include "lsu_params.svh"

module load_align (
    input  lsu_pkg::word_t   word,
    input  lsu_pkg::offset_t offset,
    input  lsu_pkg::size_t   size,
    input  logic             is_unsigned,
    output lsu_pkg::word_t   result
);

// Addressed lane moved down to bit 0
lsu_pkg::word_t shifted;

logic [7:0]  byte_val;
logic [15:0] half_val;
logic        byte_sign;
logic        half_sign;

assign shifted = word >> {offset, 3'b000};

assign byte_val = shifted[7:0];
assign half_val = shifted[15:0];

// Zero fill for the unsigned loads
assign byte_sign = byte_val[7] & ~is_unsigned;
assign half_sign = half_val[15] & ~is_unsigned;

////////////////////////////////////////
// Result select
////////////////////////////////////////

always_comb begin
    case (size)
    `LSU_SIZE_BYTE: begin
        result = {{(`LSU_DATA_W-8){byte_sign}}, byte_val};
    end
    `LSU_SIZE_HALF: begin
        result = {{(`LSU_DATA_W-16){half_sign}}, half_val};
    end
    default: begin
        // Whole word as returned
        result = word;
    end
    endcase
end

endmodule

// ==== verilog/store_align.sv ====
`timescale 1ns/1ps

`include "lsu_params.svh"

module store_align (
    input  lsu_pkg::size_t   size,
    input  lsu_pkg::offset_t offset,
    input  lsu_pkg::word_t   wdata,
    output lsu_pkg::sel_t    sel,
    output lsu_pkg::word_t   lane_data
);

////////////////////////////////////////
// Byte selects
////////////////////////////////////////

always_comb begin
    case (size)
    `LSU_SIZE_BYTE: sel = lsu_pkg::sel_t'(1'b1) << offset;
    // Lower or upper lane pair, offset 0 or 2
    `LSU_SIZE_HALF: sel = lsu_pkg::sel_t'(2'b11) << {offset[1], 1'b0};
    `LSU_SIZE_WORD: sel = '1;
    default:        sel = '0;
    endcase
end

////////////////////////////////////////
// Store data lanes
////////////////////////////////////////

// Replicated so the slave finds the value on whichever lane is selected
always_comb begin
    case (size)
    `LSU_SIZE_BYTE: begin
        lane_data = {4{wdata[7:0]}};
    end
    `LSU_SIZE_HALF: begin
        lane_data = {2{wdata[15:0]}};
    end
    default: begin
        lane_data = wdata;
    end
    endcase
end

endmodule

// ==== verilog/lsu_pkg.sv ====
`include "lsu_params.svh"

package lsu_pkg;

    // Data word on the bus and on the command side
    typedef logic [`LSU_DATA_W-1:0] word_t;

    // Byte address
    typedef logic [`LSU_ADDR_W-1:0] addr_t;

    // Wishbone byte selects
    typedef logic [`LSU_SEL_W-1:0] sel_t;

    // Byte position inside a word
    typedef logic [$clog2(`LSU_SEL_W)-1:0] offset_t;

    // Access size code
    typedef logic [1:0] size_t;

endpackage

// ==== verilog/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Bus widths
`define LSU_DATA_W 32
`define LSU_ADDR_W 32

// One select bit per byte lane
`define LSU_SEL_W 4

// Access size codes on cmd_size
`define LSU_SIZE_BYTE 2'd0
`define LSU_SIZE_HALF 2'd1
`define LSU_SIZE_WORD 2'd2

// Code 3 is unused and gives no selects

`endif
